// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fp_decode_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fp_control.sv
module fp_control (
  input  fp_dec_pkg::fp_instr_u instr,
  input  logic                  flush,
  input  logic                  hazard,
  fp_ctrl_if.dec                ctrl
);
  import fp_dec_pkg::*;

  logic              stall;
  logic              ins_zero;
  logic              bad;         // word not decodable
  logic              f7_unknown;  // OP_FP with no funct7 match
  logic              is_load;
  logic              is_store;
  logic              is_wr;
  logic [4:0]        sel;
  logic [CTRL_W-1:0] rm_d;
  logic [CTRL_W-1:0] ldc;
  logic [CTRL_W-1:0] stc;
  logic              rd1;
  logic              rd2;
  logic              rd3;

  assign ins_zero = (instr == '0);  // bubble word
  assign stall    = flush | hazard | ins_zero;

  //////////////////////////////////////////////////
  // decode, independent of stall
  //////////////////////////////////////////////////
  always_comb begin
    sel        = SEL_NONE;
    rm_d       = '0;
    ldc        = '0;
    stc        = '0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    is_wr      = 1'b0;
    bad        = 1'b0;
    f7_unknown = 1'b0;
    rd1        = 1'b0;
    rd2        = 1'b0;
    rd3        = 1'b0;

    case (instr.r.opcode)
      OP_LOAD_FP: begin
        is_load = 1'b1;
        is_wr   = 1'b1;
        if (instr.i.funct3 == 3'b010) ldc = 3'b001;  // word only
        else                          bad = 1'b1;
      end
      OP_STORE_FP: begin
        is_store = 1'b1;
        rd1      = 1'b1;
        rd2      = 1'b1;                              // store data
        if (instr.s.funct3 == 3'b010) stc = 3'b001;
        else                          bad = 1'b1;
      end
      OP_FP: begin
        is_wr = 1'b1;
        rd1   = 1'b1;  // cleared below for int sources
        case (instr.r.funct7)
          F7_FADD: begin sel = SEL_FADD; rm_d = instr.r.funct3; rd2 = 1'b1; end
          F7_FSUB: begin sel = SEL_FSUB; rm_d = instr.r.funct3; rd2 = 1'b1; end
          F7_FMUL: begin sel = SEL_FMUL; rm_d = instr.r.funct3; rd2 = 1'b1; end
          F7_FDIV: begin sel = SEL_FDIV; rm_d = instr.r.funct3; rd2 = 1'b1; end
          F7_FSQRT: begin
            rm_d = instr.r.funct3;
            if (instr.r.rs2 == 5'd0) sel = SEL_FSQRT;
            else                     bad = 1'b1;
          end
          F7_FSGNJ: begin
            rd2 = 1'b1;
            case (instr.r.funct3)
              3'b000:  sel = SEL_FSGNJ;
              3'b001:  sel = SEL_FSGNJN;
              3'b010:  sel = SEL_FSGNJX;
              default: bad = 1'b1;
            endcase
          end
          F7_FMINMAX: begin
            rd2 = 1'b1;
            case (instr.r.funct3)
              3'b000:  sel = SEL_FMIN;
              3'b001:  sel = SEL_FMAX;
              default: bad = 1'b1;
            endcase
          end
          F7_FCMP: begin
            rd2 = 1'b1;
            case (instr.r.funct3)
              3'b010:  sel = SEL_FEQ;
              3'b001:  sel = SEL_FLT;
              3'b000:  sel = SEL_FLE;
              default: bad = 1'b1;
            endcase
          end
          F7_FCVT_W_S: begin
            rm_d = instr.r.funct3;
            case (instr.r.rs2)  // rs2 picks signedness
              5'd0:    sel = SEL_FCVT_W_S;
              5'd1:    sel = SEL_FCVT_WU_S;
              default: bad = 1'b1;
            endcase
          end
          F7_FCVT_S_W: begin
            rm_d = instr.r.funct3;
            rd1  = 1'b0;  // integer source
            case (instr.r.rs2)
              5'd0:    sel = SEL_FCVT_S_W;
              5'd1:    sel = SEL_FCVT_S_WU;
              default: bad = 1'b1;
            endcase
          end
          F7_FMV_X_W: begin
            if (instr.r.rs2 != 5'd0)           bad = 1'b1;
            else if (instr.r.funct3 == 3'b000) sel = SEL_FMV_X_W;
            else if (instr.r.funct3 == 3'b001) sel = SEL_FCLASS;
            else                               bad = 1'b1;
          end
          F7_FMV_W_X: begin
            rd1 = 1'b0;  // int -> fp bit move
            if (instr.r.rs2 == 5'd0 && instr.r.funct3 == 3'b000) sel = SEL_FMV_W_X;
            else                                                 bad = 1'b1;
          end
          default: begin  // includes fmt != 00
            bad        = 1'b1;
            f7_unknown = 1'b1;
          end
        endcase
      end
      OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD: begin
        is_wr = 1'b1;
        rm_d  = instr.r4.funct3;
        rd1   = 1'b1;
        rd2   = 1'b1;
        rd3   = 1'b1;
        case (instr.r4.opcode[3:2])  // bits 3:2 pick the variant
          2'b00:   sel = SEL_FMADD;
          2'b01:   sel = SEL_FMSUB;
          2'b10:   sel = SEL_FNMSUB;
          default: sel = SEL_FNMADD;
        endcase
        if (instr.r4.fmt != 2'b00) bad = 1'b1;
      end
      default: bad = 1'b1;  // not an fp opcode
    endcase

    // undecodable word carries nothing forward
    if (bad) begin
      sel  = SEL_NONE;
      rm_d = '0;
      ldc  = '0;
      stc  = '0;
      rd1  = 1'b0;
      rd2  = 1'b0;
      rd3  = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // outputs, strobes gated by stall
  //////////////////////////////////////////////////
  assign ctrl.fpusel     = sel;
  assign ctrl.rm         = rm_d;
  assign ctrl.loadcntrl  = ldc;
  assign ctrl.storecntrl = stc;
  assign ctrl.memread    = is_load  & ~bad & ~stall;
  assign ctrl.memwrite   = is_store & ~bad & ~stall;
  assign ctrl.regwrite   = is_wr    & ~bad & ~stall;
  assign ctrl.fpusrc     = ~bad;
  assign ctrl.illegal    = bad & (~flush | f7_unknown);  // bad funct7 survives flush
  assign ctrl.rd_fp1     = rd1;
  assign ctrl.rd_fp2     = rd2;
  assign ctrl.rd_fp3     = rd3;

endmodule

// File: hw/fp_ctrl_if.sv
interface fp_ctrl_if;
  import fp_dec_pkg::*;

  logic [4:0]        fpusel;      // unit select
  logic [CTRL_W-1:0] rm;          // funct3 for rounding ops
  logic [CTRL_W-1:0] loadcntrl;   // 001 = flw
  logic [CTRL_W-1:0] storecntrl;  // 001 = fsw
  logic              memread;
  logic              memwrite;
  logic              regwrite;
  logic              fpusrc;      // recognised fp op
  logic              illegal;
  // which fields name fp sources, hazard compare only
  logic              rd_fp1;
  logic              rd_fp2;
  logic              rd_fp3;

  modport dec (output fpusel, rm, loadcntrl, storecntrl, memread, memwrite,
                      regwrite, fpusrc, illegal, rd_fp1, rd_fp2, rd_fp3);

  modport stage (input fpusel, rm, loadcntrl, storecntrl, memread, memwrite,
                       regwrite, fpusrc, illegal, rd_fp1, rd_fp2, rd_fp3);

endinterface

// File: hw/fp_dec_pkg.sv
package fp_dec_pkg;

  //////////////////////////////////////////////////
  // widths and major opcodes
  //////////////////////////////////////////////////
  localparam int CTRL_W = 3;  // rm, load and store control

  localparam logic [6:0] OP_LOAD_FP  = 7'b0000111;  // flw
  localparam logic [6:0] OP_STORE_FP = 7'b0100111;  // fsw
  localparam logic [6:0] OP_FP       = 7'b1010011;  // R-type arith, compare, cvt, mv
  localparam logic [6:0] OP_FMADD    = 7'h43;
  localparam logic [6:0] OP_FMSUB    = 7'h47;
  localparam logic [6:0] OP_FNMSUB   = 7'h4B;
  localparam logic [6:0] OP_FNMADD   = 7'h4F;

  // funct7 under OP_FP, fmt bits [1:0] always 00 for single
  localparam logic [6:0] F7_FADD     = 7'h00;
  localparam logic [6:0] F7_FSUB     = 7'h04;
  localparam logic [6:0] F7_FMUL     = 7'h08;
  localparam logic [6:0] F7_FDIV     = 7'h0C;
  localparam logic [6:0] F7_FSGNJ    = 7'h10;
  localparam logic [6:0] F7_FMINMAX  = 7'h14;
  localparam logic [6:0] F7_FSQRT    = 7'h2C;
  localparam logic [6:0] F7_FCMP     = 7'h50;
  localparam logic [6:0] F7_FCVT_W_S = 7'h60;  // fp -> int
  localparam logic [6:0] F7_FCVT_S_W = 7'h68;  // int -> fp
  localparam logic [6:0] F7_FMV_X_W  = 7'h70;  // also fclass
  localparam logic [6:0] F7_FMV_W_X  = 7'h78;

  //////////////////////////////////////////////////
  // fpu unit select
  //////////////////////////////////////////////////
  localparam logic [4:0] SEL_FADD      = 5'd0;
  localparam logic [4:0] SEL_FSUB      = 5'd1;
  localparam logic [4:0] SEL_FMUL      = 5'd2;
  localparam logic [4:0] SEL_FDIV      = 5'd3;
  localparam logic [4:0] SEL_FSQRT     = 5'd4;
  localparam logic [4:0] SEL_FSGNJ     = 5'd5;
  localparam logic [4:0] SEL_FSGNJN    = 5'd6;
  localparam logic [4:0] SEL_FSGNJX    = 5'd7;
  localparam logic [4:0] SEL_FMAX      = 5'd8;
  localparam logic [4:0] SEL_FMIN      = 5'd9;
  localparam logic [4:0] SEL_FEQ       = 5'd10;
  localparam logic [4:0] SEL_FLT       = 5'd11;
  localparam logic [4:0] SEL_FLE       = 5'd12;
  localparam logic [4:0] SEL_FMV_X_W   = 5'd13;
  localparam logic [4:0] SEL_FCLASS    = 5'd14;
  localparam logic [4:0] SEL_FMV_W_X   = 5'd15;
  localparam logic [4:0] SEL_FMADD     = 5'd16;
  localparam logic [4:0] SEL_FMSUB     = 5'd17;
  localparam logic [4:0] SEL_FNMSUB    = 5'd18;
  localparam logic [4:0] SEL_FNMADD    = 5'd19;
  localparam logic [4:0] SEL_FCVT_W_S  = 5'd20;
  localparam logic [4:0] SEL_FCVT_WU_S = 5'd21;
  localparam logic [4:0] SEL_FCVT_S_W  = 5'd22;
  localparam logic [4:0] SEL_FCVT_S_WU = 5'd23;
  localparam logic [4:0] SEL_NONE      = 5'b11111;  // no fpu op

  //////////////////////////////////////////////////
  // instruction word views
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fp_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;  // load width
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fp_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;     // store data
    logic [4:0] rs1;     // base
    logic [2:0] funct3;  // store width
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } fp_s_t;

  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;  // 00 single
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fp_r4_t;

  typedef union packed {
    fp_r_t  r;
    fp_i_t  i;
    fp_s_t  s;
    fp_r4_t r4;
  } fp_instr_u;

endpackage

// File: hw/fp_decode_top.sv
module fp_decode_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [31:0]                   instr,
  input  logic                          flush,
  output logic                          stall,          // holds fetch
  output logic [4:0]                    ex_fpusel,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_rm,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_loadcntrl,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_storecntrl,
  output logic                          ex_memread,
  output logic                          ex_memwrite,
  output logic                          ex_regwrite,
  output logic                          ex_fpusrc,
  output logic                          ex_illegal,
  output logic [4:0]                    ex_rd,
  output logic [4:0]                    ex_rs1,
  output logic [4:0]                    ex_rs2,
  output logic [4:0]                    ex_rs3
);
  import fp_dec_pkg::*;

  fp_instr_u instr_w;  // same word, field views
  assign instr_w = instr;

  fp_ctrl_if ctrl_if ();

  //////////////////////////////////////////////////
  // decoder and id/ex stage
  //////////////////////////////////////////////////
  fp_control fp_control_inst (
    .instr  (instr_w),
    .flush  (flush),
    .hazard (stall),         // load-use from stage
    .ctrl   (ctrl_if.dec)
  );

  fp_id_ex_stage fp_id_ex_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr         (instr_w),
    .ctrl          (ctrl_if.stage),
    .hazard        (stall),
    .ex_fpusel     (ex_fpusel),
    .ex_rm         (ex_rm),
    .ex_loadcntrl  (ex_loadcntrl),
    .ex_storecntrl (ex_storecntrl),
    .ex_memread    (ex_memread),
    .ex_memwrite   (ex_memwrite),
    .ex_regwrite   (ex_regwrite),
    .ex_fpusrc     (ex_fpusrc),
    .ex_illegal    (ex_illegal),
    .ex_rd         (ex_rd),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .ex_rs3        (ex_rs3)
  );

endmodule

// File: hw/fp_id_ex_stage.sv
module fp_id_ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  fp_dec_pkg::fp_instr_u         instr,
  fp_ctrl_if.stage                      ctrl,
  output logic                          hazard,
  output logic [4:0]                    ex_fpusel,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_rm,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_loadcntrl,
  output logic [fp_dec_pkg::CTRL_W-1:0] ex_storecntrl,
  output logic                          ex_memread,
  output logic                          ex_memwrite,
  output logic                          ex_regwrite,
  output logic                          ex_fpusrc,
  output logic                          ex_illegal,
  output logic [4:0]                    ex_rd,
  output logic [4:0]                    ex_rs1,
  output logic [4:0]                    ex_rs2,
  output logic [4:0]                    ex_rs3
);
  import fp_dec_pkg::*;

  logic ld_in_ex;  // fp load sitting in execute
  logic hit1;
  logic hit2;
  logic hit3;

  //////////////////////////////////////////////////
  // load-use hazard against the decoding word
  //////////////////////////////////////////////////
  assign ld_in_ex = ex_memread & (ex_loadcntrl != '0);
  assign hit1     = ctrl.rd_fp1 & (instr.r.rs1  == ex_rd);
  assign hit2     = ctrl.rd_fp2 & (instr.r.rs2  == ex_rd);
  assign hit3     = ctrl.rd_fp3 & (instr.r4.rs3 == ex_rd);  // R4 only
  assign hazard   = ld_in_ex & (hit1 | hit2 | hit3);

  //////////////////////////////////////////////////
  // id/ex register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_fpusel     <= SEL_NONE;
      ex_loadcntrl  <= '0;
      ex_storecntrl <= '0;
      ex_memread    <= 1'b0;
      ex_memwrite   <= 1'b0;
      ex_regwrite   <= 1'b0;
      ex_fpusrc     <= 1'b0;
      ex_illegal    <= 1'b0;
    end else begin
      ex_fpusel     <= ctrl.fpusel;
      ex_loadcntrl  <= ctrl.loadcntrl;
      ex_storecntrl <= ctrl.storecntrl;
      ex_memread    <= ctrl.memread;   // already low on stall
      ex_memwrite   <= ctrl.memwrite;
      ex_regwrite   <= ctrl.regwrite;
      ex_fpusrc     <= ctrl.fpusrc;
      ex_illegal    <= ctrl.illegal;
    end
  end

  // register fields and rounding mode, payload
  always_ff @(posedge clk) begin
    ex_rm  <= ctrl.rm;
    ex_rd  <= instr.r.rd;
    ex_rs1 <= instr.r.rs1;
    ex_rs2 <= instr.r.rs2;
    ex_rs3 <= instr.r4.rs3;
  end

  // store in execute always has a decoded width
  a_store_width: assert property (
    @(posedge clk) disable iff (!rst_n) ex_memwrite |-> (ex_storecntrl != '0)
  ) else $error("ex_memwrite with zero storecntrl");

  // hazard cycle becomes a bubble in execute
  a_hazard_bubble: assert property (
    @(posedge clk) disable iff (!rst_n) hazard |=> (!ex_memread && !ex_regwrite)
  ) else $error("hazard did not insert a bubble");

endmodule

// File: sim/fp_decode_checker.sv
module fp_decode_checker (
  input logic                          clk,
  input logic                          rst_n,
  input logic [31:0]                   instr,
  input logic                          flush,
  input logic                          stall,
  input logic [4:0]                    ex_fpusel,
  input logic [fp_dec_pkg::CTRL_W-1:0] ex_rm,
  input logic [fp_dec_pkg::CTRL_W-1:0] ex_loadcntrl,
  input logic [fp_dec_pkg::CTRL_W-1:0] ex_storecntrl,
  input logic                          ex_memread,
  input logic                          ex_memwrite,
  input logic                          ex_regwrite,
  input logic                          ex_fpusrc,
  input logic                          ex_illegal,
  input logic [4:0]                    ex_rd,
  input logic [4:0]                    ex_rs1,
  input logic [4:0]                    ex_rs2,
  input logic [4:0]                    ex_rs3
);
  import fp_dec_pkg::*;

  typedef struct packed {
    logic [4:0] sel;
    logic [2:0] rm;
    logic [2:0] ldc;
    logic [2:0] stc;
    logic       memread;
    logic       memwrite;
    logic       regwrite;
    logic       fpusrc;
    logic       illegal;
    logic       r1;  // fp source flags
    logic       r2;
    logic       r3;
  } exp_t;

  exp_t       m_ex = '0;  // model of the execute stage
  logic [4:0] m_rd;
  logic [4:0] m_rs1;
  logic [4:0] m_rs2;
  logic [4:0] m_rs3;
  logic       m_valid = 1'b0;
  int         errors = 0;
  int         checks = 0;
  int         stalls = 0;  // hazard cycles seen

  //////////////////////////////////////////////////
  // reference decode, straight from the F encoding
  //////////////////////////////////////////////////
  function automatic exp_t ref_decode(input logic [31:0] w, input logic flush_i,
                                      input logic hazard_i);
    exp_t       e;
    logic [6:0] op;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] r2;
    logic [4:0] sel;
    logic       bad;
    logic       unk;
    logic       stall_i;
    op  = w[6:0];
    f3  = w[14:12];
    r2  = w[24:20];
    f7  = w[31:25];
    sel = SEL_NONE;
    bad = 1'b0;
    unk = 1'b0;
    if (op == OP_LOAD_FP || op == OP_STORE_FP) begin
      bad = (f3 != 3'b010);  // word width only
    end else if (op == OP_FP) begin
      case (f7)
        F7_FADD:     sel = SEL_FADD;
        F7_FSUB:     sel = SEL_FSUB;
        F7_FMUL:     sel = SEL_FMUL;
        F7_FDIV:     sel = SEL_FDIV;
        F7_FSQRT:    if (r2 == 5'd0) sel = SEL_FSQRT;
        F7_FSGNJ:    if (f3 <= 3'd2) sel = SEL_FSGNJ + 5'(f3);  // j, jn, jx
        F7_FMINMAX:  if (f3 <= 3'd1) sel = SEL_FMIN - 5'(f3);   // 000 min, 001 max
        F7_FCMP:     if (f3 <= 3'd2) sel = SEL_FLE - 5'(f3);    // le, lt, eq
        F7_FCVT_W_S: if (r2 <= 5'd1) sel = SEL_FCVT_W_S + r2;
        F7_FCVT_S_W: if (r2 <= 5'd1) sel = SEL_FCVT_S_W + r2;
        F7_FMV_X_W:  if (r2 == 5'd0 && f3 <= 3'd1) sel = SEL_FMV_X_W + 5'(f3);
        F7_FMV_W_X:  if (r2 == 5'd0 && f3 == 3'd0) sel = SEL_FMV_W_X;
        default:     unk = 1'b1;  // any fmt other than single lands here
      endcase
      bad = (sel == SEL_NONE);
    end else if (op inside {OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD}) begin
      bad = (w[26:25] != 2'b00);
      sel = SEL_FMADD + 5'(op[3:2]);
    end else begin
      bad = 1'b1;
    end
    stall_i = flush_i | hazard_i | (w == '0);
    e       = '0;
    e.sel   = SEL_NONE;
    if (!bad) begin
      e.sel    = sel;
      e.fpusrc = 1'b1;
      if (op == OP_LOAD_FP) begin
        e.ldc      = 3'b001;
        e.memread  = !stall_i;
        e.regwrite = !stall_i;
      end else if (op == OP_STORE_FP) begin
        e.stc      = 3'b001;
        e.memwrite = !stall_i;
        e.r1       = 1'b1;
        e.r2       = 1'b1;  // store data
      end else begin
        e.regwrite = !stall_i;
        e.r1 = !(sel inside {SEL_FCVT_S_W, SEL_FCVT_S_WU, SEL_FMV_W_X});
        e.r2 = sel inside {[SEL_FADD:SEL_FDIV], [SEL_FSGNJ:SEL_FLE], [SEL_FMADD:SEL_FNMADD]};
        e.r3 = sel inside {[SEL_FMADD:SEL_FNMADD]};
        if (sel inside {[SEL_FADD:SEL_FSQRT], [SEL_FMADD:SEL_FCVT_S_WU]}) e.rm = f3;
      end
    end else begin
      e.illegal = !flush_i || unk;
    end
    return e;
  endfunction

  // fp load in the model's execute stage feeding a marked source
  function automatic logic load_use(input logic [31:0] w, input exp_t d);
    logic ld;
    ld = m_ex.memread && (m_ex.ldc != 3'd0);
    return ld && ((d.r1 && w[19:15] == m_rd) || (d.r2 && w[24:20] == m_rd) ||
                  (d.r3 && w[31:27] == m_rd));
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // execute model, one step per rising edge
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    exp_t d;
    logic hz;
    d  = ref_decode(instr, flush, 1'b0);  // read flags do not depend on stall
    hz = load_use(instr, d);
    d  = ref_decode(instr, flush, hz);
    if (!rst_n) begin  // control held, payload still loads
      d.sel      = SEL_NONE;
      d.ldc      = 3'd0;
      d.stc      = 3'd0;
      d.memread  = 1'b0;
      d.memwrite = 1'b0;
      d.regwrite = 1'b0;
      d.fpusrc   = 1'b0;
      d.illegal  = 1'b0;
    end
    m_ex    = d;
    m_rd    = instr[11:7];
    m_rs1   = instr[19:15];
    m_rs2   = instr[24:20];
    m_rs3   = instr[31:27];
    m_valid = 1'b1;
  end

  // ex outputs on the falling edge, stall once the new word has settled
  always @(negedge clk) begin
    exp_t d;
    if (m_valid) begin
      compare_field("ex_fpusel", 32'(ex_fpusel), 32'(m_ex.sel));
      compare_field("ex_rm", 32'(ex_rm), 32'(m_ex.rm));
      compare_field("ex_loadcntrl", 32'(ex_loadcntrl), 32'(m_ex.ldc));
      compare_field("ex_storecntrl", 32'(ex_storecntrl), 32'(m_ex.stc));
      compare_field("ex_memread", 32'(ex_memread), 32'(m_ex.memread));
      compare_field("ex_memwrite", 32'(ex_memwrite), 32'(m_ex.memwrite));
      compare_field("ex_regwrite", 32'(ex_regwrite), 32'(m_ex.regwrite));
      compare_field("ex_fpusrc", 32'(ex_fpusrc), 32'(m_ex.fpusrc));
      compare_field("ex_illegal", 32'(ex_illegal), 32'(m_ex.illegal));
      compare_field("ex_rd", 32'(ex_rd), 32'(m_rd));
      compare_field("ex_rs1", 32'(ex_rs1), 32'(m_rs1));
      compare_field("ex_rs2", 32'(ex_rs2), 32'(m_rs2));
      compare_field("ex_rs3", 32'(ex_rs3), 32'(m_rs3));
      #5;  // quarter period, tb has driven
      d = ref_decode(instr, flush, 1'b0);
      compare_field("stall", 32'(stall), 32'(load_use(instr, d)));
      if (stall) stalls++;
    end
  end

endmodule

// File: sim/fp_decode_tb.sv
module fp_decode_tb;
  import fp_dec_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int N_CYCLES   = 2000;
  localparam int RST_CYCLES = 8;
  localparam int WATCHDOG   = (N_CYCLES + RST_CYCLES) * CLK_PERIOD * 3 / 2;

  localparam logic [6:0] F7_LIST [0:11] = '{F7_FADD, F7_FSUB, F7_FMUL, F7_FDIV,
    F7_FSGNJ, F7_FMINMAX, F7_FSQRT, F7_FCMP, F7_FCVT_W_S, F7_FCVT_S_W,
    F7_FMV_X_W, F7_FMV_W_X};

  logic                          clk;
  logic                          rst_n;
  logic [31:0]                   instr;
  logic                          flush;
  logic                          stall;
  logic [4:0]                    ex_fpusel;
  logic [fp_dec_pkg::CTRL_W-1:0] ex_rm;
  logic [fp_dec_pkg::CTRL_W-1:0] ex_loadcntrl;
  logic [fp_dec_pkg::CTRL_W-1:0] ex_storecntrl;
  logic                          ex_memread;
  logic                          ex_memwrite;
  logic                          ex_regwrite;
  logic                          ex_fpusrc;
  logic                          ex_illegal;
  logic [4:0]                    ex_rd;
  logic [4:0]                    ex_rs1;
  logic [4:0]                    ex_rs2;
  logic [4:0]                    ex_rs3;

  logic [15:0] lfsr    = 16'd30;  // seed
  logic [4:0]  prev_rd = 5'd0;    // last dest, reused as a source

  fp_decode_top fp_decode_top_inst (.*);
  fp_decode_checker fp_decode_checker_inst (.*);

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // instruction words, legal and mutated
  //////////////////////////////////////////////////
  function automatic logic [31:0] gen_word();
    logic [2:0] kind;
    logic [3:0] idx;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [31:0] w;
    kind = 3'(take_bits(3));
    idx  = 4'(take_bits(4));
    f7   = (idx < 4'd12) ? F7_LIST[idx] : 7'(take_bits(7));  // some unknown funct7
    f3   = 3'(take_bits(3));
    rd   = 5'(take_bits(3));  // small range, frequent matches
    rs1  = (take_bits(1) == 1) ? prev_rd : 5'(take_bits(3));
    rs2  = (take_bits(1) == 1) ? prev_rd : 5'(take_bits(2));  // reaches rs2 sub-codes
    rs3  = (take_bits(1) == 1) ? prev_rd : 5'(take_bits(3));
    fmt  = (take_bits(2) == 0) ? 2'(take_bits(2)) : 2'b00;
    case (kind)
      3'd0: begin  // flw, mostly word width
        if (take_bits(2) != 0) f3 = 3'b010;
        w = {12'(take_bits(12)), rs1, f3, rd, OP_LOAD_FP};
      end
      3'd1: begin  // fsw
        if (take_bits(2) != 0) f3 = 3'b010;
        w = {7'(take_bits(7)), rs2, rs1, f3, 5'(take_bits(5)), OP_STORE_FP};
      end
      3'd4:    w = {rs3, fmt, rs2, rs1, f3, rd, 3'b100, 2'(take_bits(2)), 2'b11};  // R4
      3'd5:    w = take_bits(32);  // mostly unknown opcode
      3'd6:    w = '0;             // bubble word
      default: w = {f7, rs2, rs1, f3, rd, OP_FP};
    endcase
    prev_rd = rd;
    return w;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus, driven on the falling edge
  //////////////////////////////////////////////////
  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    instr = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (N_CYCLES) begin
      @(negedge clk);
      if (!stall) instr = gen_word();  // held word under load-use stall
      flush = (take_bits(3) == 0);     // about 1 in 8
    end
    @(negedge clk);
    #(CLK_PERIOD / 2);  // let the last compares finish
    $display("errors %0d, checks %0d, stall cycles %0d", fp_decode_checker_inst.errors,
             fp_decode_checker_inst.checks, fp_decode_checker_inst.stalls);
    if (fp_decode_checker_inst.errors == 0 && fp_decode_checker_inst.checks > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #WATCHDOG;
    $display("run did not finish within %0d time units", WATCHDOG);
    $display("tests failed");
    $finish;
  end

endmodule

// File: sources.f
hw/fp_dec_pkg.sv
hw/fp_ctrl_if.sv
hw/fp_control.sv
hw/fp_id_ex_stage.sv
hw/fp_decode_top.sv
sim/fp_decode_checker.sv
sim/fp_decode_tb.sv
